// ==== rtl/ooo_cfg_pkg.sv ====
// Size and width constants of the out-of-order core slice
`default_nettype none

package ooo_cfg_pkg;

    // Datapath
    parameter int XLEN          = 16;

    // Register counts
    parameter int ARCH_REG_NUM  = 8;            // Architectural registers
    parameter int PHY_REG_NUM   = 16;           // Physical registers

    // Buffer depths, powers of two so the pointers wrap on their own
    parameter int ROB_ENTRY_NUM = 8;
    parameter int IQ_ENTRY_NUM  = 4;            // Default, top level may override

    // Derived index widths
    parameter int ARCH_IDX_W    = $clog2(ARCH_REG_NUM);
    parameter int PHY_IDX_W     = $clog2(PHY_REG_NUM);
    parameter int ROB_IDX_W     = $clog2(ROB_ENTRY_NUM);

endpackage

`default_nettype wire

// ==== rtl/ooo_types_pkg.sv ====
// Opcode encoding and the packed structs passed between pipeline stages
`default_nettype none

package ooo_types_pkg;

    import ooo_cfg_pkg::*;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_LI  = 3'd4                           // Load immediate, no sources
    } alu_op_e;

    // Decoded instruction at the dispatch port
    typedef struct packed {
        alu_op_e                op;
        logic [ARCH_IDX_W-1:0]  rd;
        logic [ARCH_IDX_W-1:0]  rs1;
        logic [ARCH_IDX_W-1:0]  rs2;
        logic [XLEN-1:0]        imm;
    } dp_inst_t;

    // Rename result
    typedef struct packed {
        logic [PHY_IDX_W-1:0]   pd;             // New destination tag
        logic [PHY_IDX_W-1:0]   pd_old;         // Previous mapping of rd
        logic [PHY_IDX_W-1:0]   ps1;
        logic [PHY_IDX_W-1:0]   ps2;
    } rename_t;

    // One issue queue slot
    typedef struct packed {
        alu_op_e                op;
        logic [PHY_IDX_W-1:0]   ps1;
        logic                   ps1_rdy;
        logic [PHY_IDX_W-1:0]   ps2;
        logic                   ps2_rdy;
        logic [XLEN-1:0]        imm;
        logic [PHY_IDX_W-1:0]   pd;
        logic [ROB_IDX_W-1:0]   rob_idx;
    } iq_entry_t;

    // Issued operation with operand values
    typedef struct packed {
        logic                   valid;
        alu_op_e                op;
        logic [XLEN-1:0]        val_a;
        logic [XLEN-1:0]        val_b;
        logic [XLEN-1:0]        imm;
        logic [PHY_IDX_W-1:0]   pd;
        logic [ROB_IDX_W-1:0]   rob_idx;
    } fu_req_t;

    // Common result bus
    typedef struct packed {
        logic                   valid;
        logic [PHY_IDX_W-1:0]   tag;
        logic [ROB_IDX_W-1:0]   rob_idx;
        logic [XLEN-1:0]        value;
    } cdb_t;

    // Retire payload
    typedef struct packed {
        logic [ARCH_IDX_W-1:0]  rd;
        logic [XLEN-1:0]        value;
        logic [PHY_IDX_W-1:0]   freed_tag;      // Old tag of rd, back to the free list
    } retire_t;

endpackage

`default_nettype wire

// ==== rtl/rename_unit.sv ====
// Register rename stage with the map table and a FIFO free list of physical tags
`default_nettype none
`timescale 1ns/1ps

module rename_unit (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                dp_accept_i,      // Dispatch accept strobe
    input  ooo_types_pkg::dp_inst_t             dp_inst_i,
    output logic                                free_avail_o,     // At least one free tag
    output ooo_types_pkg::rename_t              rename_o,
    input  logic                                release_valid_i,  // Retire frees a tag
    input  logic [ooo_cfg_pkg::PHY_IDX_W-1:0]   release_tag_i
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    localparam int FL_NUM   = PHY_REG_NUM - ARCH_REG_NUM;
    localparam int FL_IDX_W = $clog2(FL_NUM);

    logic [PHY_IDX_W-1:0]   map_q [ARCH_REG_NUM];       // Speculative map table
    logic [PHY_IDX_W-1:0]   fl_q  [FL_NUM];             // Free tag ring
    logic [FL_IDX_W-1:0]    head_q;                     // Next tag to hand out
    logic [FL_IDX_W-1:0]    tail_q;                     // Next slot for a freed tag
    logic [FL_IDX_W:0]      cnt_q;

    // ------------------------------------------------------------
    // Lookup
    // ------------------------------------------------------------
    // Sources read the table before this instruction's own update,
    // so reading rd yields the older producer
    always_comb begin
        rename_o.pd     = fl_q[head_q];
        rename_o.pd_old = map_q[dp_inst_i.rd];
        rename_o.ps1    = map_q[dp_inst_i.rs1];
        rename_o.ps2    = map_q[dp_inst_i.rs2];
    end

    assign free_avail_o = (cnt_q != '0);

    // ------------------------------------------------------------
    // Table and free list update
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int r = 0; r < ARCH_REG_NUM; r++) begin
                map_q[r] <= PHY_IDX_W'(r);                  // Identity mapping
            end
            for (int f = 0; f < FL_NUM; f++) begin
                fl_q[f] <= PHY_IDX_W'(ARCH_REG_NUM + f);    // Upper tags start free
            end
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= (FL_IDX_W+1)'(FL_NUM);
        end else begin
            if (dp_accept_i) begin
                map_q[dp_inst_i.rd] <= fl_q[head_q];
                head_q              <= head_q + 1'b1;       // Wraps at FL_NUM
            end
            if (release_valid_i) begin
                fl_q[tail_q] <= release_tag_i;
                tail_q       <= tail_q + 1'b1;
            end
            unique case ({dp_accept_i, release_valid_i})
                2'b10:   cnt_q <= cnt_q - 1'b1;
                2'b01:   cnt_q <= cnt_q + 1'b1;
                default: cnt_q <= cnt_q;                    // Both or neither
            endcase
        end
    end

    // Dispatch must never pop an empty free list
    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) dp_accept_i |-> free_avail_o
    ) else $error("rename_unit pop while free list empty");

endmodule

`default_nettype wire

// ==== rtl/reorder_buffer.sv ====
// Circular reorder buffer completing from the result bus and retiring in order
`default_nettype none
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                dp_accept_i,
    input  logic [ooo_cfg_pkg::ARCH_IDX_W-1:0]  dp_rd_i,
    input  logic [ooo_cfg_pkg::PHY_IDX_W-1:0]   prev_tag_i,       // Tag freed at retire
    output logic                                space_o,
    output logic [ooo_cfg_pkg::ROB_IDX_W-1:0]   tail_idx_o,       // Index of the new entry
    input  ooo_types_pkg::cdb_t                 cdb_i,
    output logic                                retire_valid_o,
    output ooo_types_pkg::retire_t              retire_o,
    input  logic                                retire_ready_i
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    // Entry payload
    logic [ARCH_IDX_W-1:0]      rd_q   [ROB_ENTRY_NUM];
    logic [PHY_IDX_W-1:0]       prev_q [ROB_ENTRY_NUM];
    logic [XLEN-1:0]            val_q  [ROB_ENTRY_NUM];

    // Entry state and pointers
    logic [ROB_ENTRY_NUM-1:0]   vld_q;
    logic [ROB_ENTRY_NUM-1:0]   done_q;
    logic [ROB_IDX_W-1:0]       head_q;
    logic [ROB_IDX_W-1:0]       tail_q;
    logic [ROB_IDX_W:0]         cnt_q;
    logic                       retire_fire;

    assign space_o        = (cnt_q != (ROB_IDX_W+1)'(ROB_ENTRY_NUM));
    assign tail_idx_o     = tail_q;
    assign retire_valid_o = vld_q[head_q] & done_q[head_q];   // Only a finished head leaves
    assign retire_fire    = retire_valid_o & retire_ready_i;

    always_comb begin
        retire_o.rd        = rd_q[head_q];
        retire_o.value     = val_q[head_q];
        retire_o.freed_tag = prev_q[head_q];
    end

    // Entry payload from dispatch and the result bus
    always_ff @(posedge clk_i) begin
        if (dp_accept_i) begin
            rd_q[tail_q]   <= dp_rd_i;
            prev_q[tail_q] <= prev_tag_i;
        end
        if (cdb_i.valid) begin
            val_q[cdb_i.rob_idx] <= cdb_i.value;
        end
    end

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q  <= '0;
            done_q <= '0;
            head_q <= '0;
            tail_q <= '0;
            cnt_q  <= '0;
        end else begin
            if (cdb_i.valid) done_q[cdb_i.rob_idx] <= 1'b1;     // Complete
            if (retire_fire) begin
                vld_q[head_q] <= 1'b0;
                head_q        <= head_q + 1'b1;
            end
            if (dp_accept_i) begin                             // Never the head slot when full
                vld_q[tail_q]  <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            unique case ({dp_accept_i, retire_fire})
                2'b10:   cnt_q <= cnt_q + 1'b1;
                2'b01:   cnt_q <= cnt_q - 1'b1;
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    // Result bus may only target a live entry
    a_cdb_to_live: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) cdb_i.valid |-> vld_q[cdb_i.rob_idx]
    ) else $error("reorder_buffer result for empty entry");

endmodule

`default_nettype wire

// ==== rtl/phys_reg_file.sv ====
// Physical register file with ready bits, dispatch lookup and issue read ports
`default_nettype none
`timescale 1ns/1ps

module phys_reg_file (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic [1:0][ooo_cfg_pkg::PHY_IDX_W-1:0]  lookup_tags_i,    // Source tags at dispatch
    output logic [1:0]                              lookup_ready_o,
    input  logic                                    alloc_valid_i,
    input  logic [ooo_cfg_pkg::PHY_IDX_W-1:0]       alloc_tag_i,
    input  logic [ooo_cfg_pkg::PHY_IDX_W-1:0]       rd_tag_a_i,
    input  logic [ooo_cfg_pkg::PHY_IDX_W-1:0]       rd_tag_b_i,
    output logic [ooo_cfg_pkg::XLEN-1:0]            rd_val_a_o,
    output logic [ooo_cfg_pkg::XLEN-1:0]            rd_val_b_o,
    input  ooo_types_pkg::cdb_t                     cdb_i
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    logic [XLEN-1:0]        val_q [PHY_REG_NUM];
    logic [PHY_REG_NUM-1:0] rdy_q;

    // Combinational reads
    assign lookup_ready_o[0] = rdy_q[lookup_tags_i[0]];
    assign lookup_ready_o[1] = rdy_q[lookup_tags_i[1]];
    assign rd_val_a_o        = val_q[rd_tag_a_i];
    assign rd_val_b_o        = val_q[rd_tag_b_i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int t = 0; t < PHY_REG_NUM; t++) begin
                val_q[t] <= '0;
                rdy_q[t] <= (t < ARCH_REG_NUM);     // Initial mappings hold zero
            end
        end else begin
            if (cdb_i.valid) begin
                val_q[cdb_i.tag] <= cdb_i.value;
                rdy_q[cdb_i.tag] <= 1'b1;
            end
            if (alloc_valid_i) rdy_q[alloc_tag_i] <= 1'b0;  // Fresh tag, never the bus tag
        end
    end

    // A tag is written once per allocation
    a_single_write: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) cdb_i.valid |-> !rdy_q[cdb_i.tag]
    ) else $error("phys_reg_file write to tag already ready");

endmodule

`default_nettype wire

// ==== rtl/issue_queue.sv ====
// Issue queue with result bus wakeup and lowest-index ready select
`default_nettype none
`timescale 1ns/1ps

module issue_queue #(
    parameter int IQ_DEPTH = ooo_cfg_pkg::IQ_ENTRY_NUM
) (
    input  logic                                clk_i,
    input  logic                                rst_n_i,
    input  logic                                dp_accept_i,
    input  ooo_types_pkg::rename_t              rename_i,
    input  ooo_types_pkg::dp_inst_t             dp_inst_i,
    input  logic [1:0]                          src_ready_i,      // From register file lookup
    input  logic [ooo_cfg_pkg::ROB_IDX_W-1:0]   rob_idx_i,
    output logic                                space_o,
    input  ooo_types_pkg::cdb_t                 cdb_i,
    output logic [ooo_cfg_pkg::PHY_IDX_W-1:0]   rd_tag_a_o,
    output logic [ooo_cfg_pkg::PHY_IDX_W-1:0]   rd_tag_b_o,
    input  logic [ooo_cfg_pkg::XLEN-1:0]        rd_val_a_i,
    input  logic [ooo_cfg_pkg::XLEN-1:0]        rd_val_b_i,
    output ooo_types_pkg::fu_req_t              fu_req_o
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    localparam int IDX_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    iq_entry_t              q_q [IQ_DEPTH];
    logic [IQ_DEPTH-1:0]    vld_q;
    iq_entry_t              new_ent;
    logic [IDX_W-1:0]       ins_idx;            // Lowest free slot
    logic [IDX_W-1:0]       iss_idx;            // Lowest ready slot
    logic                   iss_vld;
    logic                   is_li;

    assign space_o = |(~vld_q);
    assign is_li   = (dp_inst_i.op == OP_LI);

    // New slot, same-cycle bus result folded into the ready bits
    always_comb begin
        new_ent.op      = dp_inst_i.op;
        new_ent.ps1     = rename_i.ps1;
        new_ent.ps1_rdy = is_li | src_ready_i[0] | (cdb_i.valid && cdb_i.tag == rename_i.ps1);
        new_ent.ps2     = rename_i.ps2;
        new_ent.ps2_rdy = is_li | src_ready_i[1] | (cdb_i.valid && cdb_i.tag == rename_i.ps2);
        new_ent.imm     = dp_inst_i.imm;
        new_ent.pd      = rename_i.pd;
        new_ent.rob_idx = rob_idx_i;
    end

    // ------------------------------------------------------------
    // Slot search, descending loops so the lowest index wins
    // ------------------------------------------------------------
    always_comb begin
        ins_idx = '0;
        iss_idx = '0;
        iss_vld = 1'b0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!vld_q[i]) ins_idx = IDX_W'(i);
            if (vld_q[i] && q_q[i].ps1_rdy && q_q[i].ps2_rdy) begin
                iss_idx = IDX_W'(i);
                iss_vld = 1'b1;
            end
        end
    end

    // Operand read and request
    assign rd_tag_a_o = q_q[iss_idx].ps1;
    assign rd_tag_b_o = q_q[iss_idx].ps2;

    always_comb begin
        fu_req_o.valid   = iss_vld;
        fu_req_o.op      = q_q[iss_idx].op;
        fu_req_o.val_a   = rd_val_a_i;
        fu_req_o.val_b   = rd_val_b_i;
        fu_req_o.imm     = q_q[iss_idx].imm;
        fu_req_o.pd      = q_q[iss_idx].pd;
        fu_req_o.rob_idx = q_q[iss_idx].rob_idx;
    end

    // Slot payload with wakeup
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (cdb_i.valid && q_q[i].ps1 == cdb_i.tag) q_q[i].ps1_rdy <= 1'b1;
            if (cdb_i.valid && q_q[i].ps2 == cdb_i.tag) q_q[i].ps2_rdy <= 1'b1;
        end
        if (dp_accept_i) q_q[ins_idx] <= new_ent;         // Free slot, never woken above
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            if (iss_vld)     vld_q[iss_idx] <= 1'b0;        // Issue frees the slot
            if (dp_accept_i) vld_q[ins_idx] <= 1'b1;
        end
    end

    // Core accept must respect queue space
    a_no_insert_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) dp_accept_i |-> space_o
    ) else $error("issue_queue insert while full");

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
// Single-cycle integer ALU driving the registered result bus
`default_nettype none
`timescale 1ns/1ps

module alu_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  ooo_types_pkg::fu_req_t  fu_req_i,
    output ooo_types_pkg::cdb_t     cdb_o
);

    import ooo_types_pkg::*;

    cdb_t res_d;
    cdb_t res_q;                        // Payload register
    logic vld_q;

    always_comb begin
        res_d.valid   = fu_req_i.valid;
        res_d.tag     = fu_req_i.pd;
        res_d.rob_idx = fu_req_i.rob_idx;
        unique case (fu_req_i.op)
            OP_ADD:  res_d.value = fu_req_i.val_a + fu_req_i.val_b;   // Wraps at 2^16
            OP_SUB:  res_d.value = fu_req_i.val_a - fu_req_i.val_b;
            OP_AND:  res_d.value = fu_req_i.val_a & fu_req_i.val_b;
            OP_XOR:  res_d.value = fu_req_i.val_a ^ fu_req_i.val_b;
            OP_LI:   res_d.value = fu_req_i.imm;
            default: res_d.value = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) vld_q <= 1'b0;
        else          vld_q <= res_d.valid;
    end

    always_ff @(posedge clk_i) res_q <= res_d;

    // Bus valid comes from the reset flop
    always_comb begin
        cdb_o       = res_q;
        cdb_o.valid = vld_q;
    end

endmodule

`default_nettype wire

// ==== rtl/ooo_core.sv ====
// Top level of the out-of-order core slice joining rename, ROB, PRF, issue queue and ALU
`default_nettype none
`timescale 1ns/1ps

module ooo_core #(
    parameter int IQ_DEPTH = ooo_cfg_pkg::IQ_ENTRY_NUM
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        inst_valid_i,
    input  ooo_types_pkg::dp_inst_t     inst_i,
    output logic                        inst_ready_o,
    output logic                        retire_valid_o,
    output ooo_types_pkg::retire_t      retire_o,
    input  logic                        retire_ready_i
);

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    rename_t                rn;
    cdb_t                   cdb;
    fu_req_t                fu_req;
    logic                   free_avail;
    logic                   rob_space;
    logic                   iq_space;
    logic                   dp_accept;
    logic [1:0]             src_rdy;
    logic [ROB_IDX_W-1:0]   rob_tail;
    logic [PHY_IDX_W-1:0]   rd_tag_a;
    logic [PHY_IDX_W-1:0]   rd_tag_b;
    logic [XLEN-1:0]        rd_val_a;
    logic [XLEN-1:0]        rd_val_b;
    logic                   release_valid;

    // ------------------------------------------------------------
    // Dispatch handshake, one accept shared by every stage
    // ------------------------------------------------------------
    assign inst_ready_o  = free_avail & rob_space & iq_space;
    assign dp_accept     = inst_valid_i & inst_ready_o;
    assign release_valid = retire_valid_o & retire_ready_i;     // Old tag goes back

    rename_unit u_rename (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .dp_accept_i     (dp_accept),
        .dp_inst_i       (inst_i),
        .free_avail_o    (free_avail),
        .rename_o        (rn),
        .release_valid_i (release_valid),
        .release_tag_i   (retire_o.freed_tag)
    );

    reorder_buffer u_rob (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .dp_accept_i    (dp_accept),
        .dp_rd_i        (inst_i.rd),
        .prev_tag_i     (rn.pd_old),
        .space_o        (rob_space),
        .tail_idx_o     (rob_tail),
        .cdb_i          (cdb),
        .retire_valid_o (retire_valid_o),
        .retire_o       (retire_o),
        .retire_ready_i (retire_ready_i)
    );

    phys_reg_file u_prf (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lookup_tags_i  ({rn.ps2, rn.ps1}),
        .lookup_ready_o (src_rdy),
        .alloc_valid_i  (dp_accept),
        .alloc_tag_i    (rn.pd),
        .rd_tag_a_i     (rd_tag_a),
        .rd_tag_b_i     (rd_tag_b),
        .rd_val_a_o     (rd_val_a),
        .rd_val_b_o     (rd_val_b),
        .cdb_i          (cdb)
    );

    issue_queue #(
        .IQ_DEPTH (IQ_DEPTH)
    ) u_iq (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .dp_accept_i (dp_accept),
        .rename_i    (rn),
        .dp_inst_i   (inst_i),
        .src_ready_i (src_rdy),
        .rob_idx_i   (rob_tail),
        .space_o     (iq_space),
        .cdb_i       (cdb),
        .rd_tag_a_o  (rd_tag_a),
        .rd_tag_b_o  (rd_tag_b),
        .rd_val_a_i  (rd_val_a),
        .rd_val_b_i  (rd_val_b),
        .fu_req_o    (fu_req)
    );

    // Result bus fans out to PRF, issue queue and ROB
    alu_unit u_alu (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .fu_req_i (fu_req),
        .cdb_o    (cdb)
    );

endmodule

`default_nettype wire

// ==== verif/tb_ooo_core.sv ====
// Table-driven testbench for the out-of-order core slice with a golden register model
`default_nettype none
`timescale 1ns/1ps

module tb_ooo_core;

    import ooo_cfg_pkg::*;
    import ooo_types_pkg::*;

    localparam real CLK_PERIOD = 4.0;
    localparam real DRIVE_DLY  = 0.5;           // Input skew after the rising edge
    localparam int  N_ROWS     = 24;
    localparam int  WAIT_LIMIT = 200;           // Cycles allowed per wait loop
    localparam int  HOLD_CYC   = 20;            // Retire stall length

    // One stimulus row with its expected result
    typedef struct packed {
        alu_op_e                op;
        logic [ARCH_IDX_W-1:0]  rd;
        logic [ARCH_IDX_W-1:0]  rs1;
        logic [ARCH_IDX_W-1:0]  rs2;
        logic [XLEN-1:0]        imm;
        logic [XLEN-1:0]        exp;
    } row_t;

    logic     clk;
    logic     rst_n;
    logic     inst_valid;
    dp_inst_t inst;
    logic     inst_ready;
    logic     retire_valid;
    retire_t  retire;
    logic     retire_ready;

    row_t     rows [N_ROWS];
    logic [PHY_IDX_W-1:0] freed_log [N_ROWS];   // Expected freed tags in retire order
    int       seed;
    int       pass_cnt;
    int       err_cnt;
    int       retired_cnt;                      // Transfers seen on the retire port
    logic     stream_done;

    always #(CLK_PERIOD / 2.0) clk = ~clk;

    ooo_core #(
        .IQ_DEPTH (IQ_ENTRY_NUM)
    ) u_ooo_core (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst),
        .inst_ready_o   (inst_ready),
        .retire_valid_o (retire_valid),
        .retire_o       (retire),
        .retire_ready_i (retire_ready)
    );

    // Reference result per opcode with 16-bit wrap
    function automatic logic [XLEN-1:0] alu_rule(input alu_op_e op, input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b,
                                                 input logic [XLEN-1:0] imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_LI:   return imm;
            default: return '0;
        endcase
    endfunction

    // Tag handed out by the n-th rename in free list order
    function automatic logic [PHY_IDX_W-1:0] issued_tag(input int n);
        if (n < PHY_REG_NUM - ARCH_REG_NUM) begin
            return PHY_IDX_W'(ARCH_REG_NUM + n);    // Reset contents of the free list
        end
        return freed_log[n - (PHY_REG_NUM - ARCH_REG_NUM)];
    endfunction

    // Tag that rd of row k maps to just before row k renames it
    function automatic logic [PHY_IDX_W-1:0] prev_mapping(input int k);
        logic [PHY_IDX_W-1:0] tag;
        tag = PHY_IDX_W'(rows[k].rd);               // Reset maps r to tag r
        for (int j = 0; j < k; j++) begin
            if (rows[j].rd == rows[k].rd) tag = issued_tag(j);
        end
        return tag;
    endfunction

    function automatic void set_row(input int k, input alu_op_e op, input int rd, input int rs1,
                                    input int rs2, input int imm, input int exp);
        rows[k].op  = op;
        rows[k].rd  = ARCH_IDX_W'(rd);
        rows[k].rs1 = ARCH_IDX_W'(rs1);
        rows[k].rs2 = ARCH_IDX_W'(rs2);
        rows[k].imm = XLEN'(imm);
        rows[k].exp = XLEN'(exp);
    endfunction

    // ------------------------------------------------------------
    // Stimulus table with columns op rd rs1 rs2 imm expected
    // ------------------------------------------------------------
    function automatic void build_table();
        set_row( 0, OP_LI,  1, 0, 0, 'h0005, 'h0005);
        set_row( 1, OP_LI,  2, 0, 0, 'h0003, 'h0003);
        set_row( 2, OP_ADD, 3, 1, 2, 'h0000, 'h0008);   // Chain starts
        set_row( 3, OP_SUB, 4, 3, 1, 'h0000, 'h0003);
        set_row( 4, OP_XOR, 5, 4, 3, 'h0000, 'h000b);
        set_row( 5, OP_AND, 6, 5, 3, 'h0000, 'h0008);
        set_row( 6, OP_ADD, 3, 3, 3, 'h0000, 'h0010);   // Reads own rd
        set_row( 7, OP_SUB, 7, 0, 1, 'h0000, 'hfffb);   // Negative wrap
        set_row( 8, OP_LI,  1, 0, 0, 'h1234, 'h1234);
        set_row( 9, OP_ADD, 1, 1, 1, 'h0000, 'h2468);
        set_row(10, OP_XOR, 1, 1, 7, 'h0000, 'hdb93);
        set_row(11, OP_AND, 2, 1, 2, 'h0000, 'h0003);
        set_row(12, OP_LI,  0, 0, 0, 'hffff, 'hffff);
        set_row(13, OP_ADD, 4, 0, 2, 'h0000, 'h0002);   // Carry out dropped
        set_row(14, OP_SUB, 5, 4, 6, 'h0000, 'hfffa);
        set_row(15, OP_XOR, 6, 6, 6, 'h0000, 'h0000);
        set_row(16, OP_ADD, 7, 7, 5, 'h0000, 'hfff5);
        set_row(17, OP_LI,  3, 0, 0, 'h00ff, 'h00ff);
        set_row(18, OP_AND, 3, 3, 1, 'h0000, 'h0093);
        set_row(19, OP_SUB, 2, 3, 2, 'h0000, 'h0090);
        set_row(20, OP_ADD, 6, 2, 3, 'h0000, 'h0123);
        set_row(21, OP_XOR, 0, 0, 6, 'h0000, 'hfedc);
        set_row(22, OP_LI,  5, 0, 0, 'ha5a5, 'ha5a5);
        set_row(23, OP_SUB, 5, 5, 0, 'h0000, 'ha6c9);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, inout int test_err);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
            test_err++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_timeout(input string what, inout int test_err);
        $display("Timeout at %0t: %s", $time, what);
        err_cnt++;
        test_err++;
    endtask

    // Holds one row on the dispatch port until it is accepted
    task automatic send_row(input int k, inout int test_err, output logic accepted);
        int waited;
        inst.op    = rows[k].op;
        inst.rd    = rows[k].rd;
        inst.rs1   = rows[k].rs1;
        inst.rs2   = rows[k].rs2;
        inst.imm   = rows[k].imm;
        inst_valid = 1'b1;
        waited     = 0;
        accepted   = 1'b0;
        while (!accepted && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
            accepted = inst_ready;              // Transfer at this edge
        end
        if (!accepted) report_timeout($sformatf("dispatch of row %0d never accepted", k),
                                      test_err);
        #(DRIVE_DLY);
    endtask

    task automatic dispatch_all(inout int test_err);
        logic ok;
        for (int k = 0; k < N_ROWS; k++) begin
            send_row(k, test_err, ok);
            if (!ok) break;
        end
        inst_valid = 1'b0;
    endtask

    // Retirements must follow table order with the table's values
    task automatic collect_retires(inout int test_err);
        int                   waited;
        logic                 fired;
        logic [PHY_IDX_W-1:0] exp_tag;
        for (int k = 0; k < N_ROWS; k++) begin
            exp_tag      = prev_mapping(k);
            freed_log[k] = exp_tag;             // Goes back to the free list tail
            waited       = 0;
            fired        = 1'b0;
            while (!fired && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
                fired = retire_valid & retire_ready;
            end
            if (!fired) begin
                report_timeout($sformatf("row %0d never retired", k), test_err);
                break;
            end
            check_value("retire_o.rd", 32'(retire.rd), 32'(rows[k].rd), test_err);
            check_value("retire_o.value", 32'(retire.value), 32'(rows[k].exp), test_err);
            check_value("retire_o.freed_tag", 32'(retire.freed_tag), 32'(exp_tag), test_err);
            retired_cnt++;
        end
        check_value("retire count", 32'(retired_cnt), 32'(N_ROWS), test_err);
        stream_done = 1'b1;
    endtask

    // Random ready followed by a long stall and a mostly ready tail
    task automatic drive_retire_ready(inout int test_err);
        int      cyc;
        logic    low_seen;
        logic    held_vld;
        retire_t held;
        for (cyc = 0; cyc < 6; cyc++) begin
            retire_ready = 1'($random(seed));
            @(posedge clk);
            #(DRIVE_DLY);
        end
        retire_ready = 1'b0;
        low_seen     = 1'b0;
        held_vld     = 1'b0;
        held         = '0;
        for (cyc = 0; cyc < HOLD_CYC; cyc++) begin
            @(posedge clk);
            if (!inst_ready) low_seen = 1'b1;   // ROB full stops dispatch
            if (held_vld) begin                 // Head and payload frozen
                check_value("retire_valid_o during stall", 32'(retire_valid), 32'd1,
                            test_err);
                check_value("retire_o during stall", 32'(retire), 32'(held), test_err);
            end else if (retire_valid) begin
                held_vld = 1'b1;
                held     = retire;
            end
            #(DRIVE_DLY);
        end
        check_value("inst_ready_o low during stall", 32'(low_seen), 32'd1, test_err);
        check_value("retire_valid_o seen during stall", 32'(held_vld), 32'd1, test_err);
        cyc = 0;
        while (!stream_done && cyc < N_ROWS * WAIT_LIMIT) begin
            retire_ready = (($random(seed) & 3) != 0);
            @(posedge clk);
            #(DRIVE_DLY);
            cyc++;
        end
        if (!stream_done) report_timeout("retire stream did not finish", test_err);
        retire_ready = 1'b1;
        $display("Test back_pressure: %0d errors", test_err);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        logic [XLEN-1:0] gold [ARCH_REG_NUM];
        logic [XLEN-1:0] val;
        int table_err;
        int reset_err;
        int disp_err;
        int stream_err;
        int bp_err;
        int drain_err;
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        retire_ready = 1'b0;
        seed         = 32'hfff8_08cf;
        pass_cnt     = 0;
        err_cnt      = 0;
        retired_cnt  = 0;
        stream_done  = 1'b0;
        table_err    = 0;
        reset_err    = 0;
        disp_err     = 0;
        stream_err   = 0;
        bp_err       = 0;
        drain_err    = 0;

        build_table();
        for (int r = 0; r < ARCH_REG_NUM; r++) gold[r] = '0;
        for (int k = 0; k < N_ROWS; k++) begin
            val = alu_rule(rows[k].op, gold[rows[k].rs1], gold[rows[k].rs2], rows[k].imm);
            check_value($sformatf("rows[%0d].exp", k), 32'(rows[k].exp), 32'(val), table_err);
            gold[rows[k].rd] = val;             // Newest write wins
        end
        $display("Test table_model: %0d errors", table_err);

        repeat (3) @(posedge clk);
        check_value("retire_valid_o in reset", 32'(retire_valid), 32'd0, reset_err);
        #(DRIVE_DLY);
        rst_n = 1'b1;
        @(posedge clk);
        check_value("inst_ready_o after reset", 32'(inst_ready), 32'd1, reset_err);
        check_value("retire_valid_o after reset", 32'(retire_valid), 32'd0, reset_err);
        #(DRIVE_DLY);
        $display("Test reset_state: %0d errors", reset_err);

        fork
            dispatch_all(disp_err);
            collect_retires(stream_err);
            drive_retire_ready(bp_err);
        join
        $display("Test retire_stream: %0d errors", disp_err + stream_err);

        // Nothing may retire twice once the table is drained
        repeat (5) begin
            @(posedge clk);
            check_value("retire_valid_o after drain", 32'(retire_valid), 32'd0, drain_err);
        end
        $display("Test drain: %0d errors", drain_err);

        $display("Checks passed %0d, errors %0d", pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/ooo_cfg_pkg.sv
rtl/ooo_types_pkg.sv
rtl/rename_unit.sv
rtl/reorder_buffer.sv
rtl/phys_reg_file.sv
rtl/issue_queue.sv
rtl/alu_unit.sv
rtl/ooo_core.sv
verif/tb_ooo_core.sv

// ==== Makefile ====
# Verilator build and run of the out-of-order core slice testbench

VERILATOR ?= verilator
TOP       ?= tb_ooo_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
